// ==== haar_pkg.sv ====
package haar_pkg;

   localparam int win_size    = 8;
   localparam int feature_num = 8;
   localparam int stage_num   = 3;
   localparam int stage_len [stage_num] = '{2, 3, 3};

   typedef logic        [13:0] ii_t;
   typedef logic        [6:0]  addr_t;     // row * 9 + col
   typedef logic signed [2:0]  weight_t;   // 0 marks an unused rectangle
   typedef logic signed [17:0] rsum_t;
   typedef logic signed [19:0] fsum_t;
   typedef logic        [15:0] stddev_t;
   typedef logic signed [9:0]  fthr_t;
   typedef logic signed [9:0]  leaf_t;
   typedef logic signed [13:0] ssum_t;

   typedef struct packed {
      addr_t r0;
      addr_t r1;
      addr_t r2;
   } addr3_t;

   typedef struct packed {
      ii_t d0;
      ii_t d1;
      ii_t d2;
   } din3_t;

   typedef struct packed {
      weight_t w0;
      weight_t w1;
      weight_t w2;
   } wgt3_t;

   // x, y, width, height per rectangle
   localparam int rect_tab [feature_num][3][4] = '{
      '{'{0, 0, 8, 8}, '{0, 0, 8, 4}, '{0, 0, 0, 0}},
      '{'{0, 0, 8, 8}, '{0, 0, 4, 8}, '{0, 0, 0, 0}},
      '{'{0, 0, 8, 6}, '{0, 2, 8, 2}, '{0, 0, 0, 0}},
      '{'{0, 0, 6, 8}, '{2, 0, 2, 8}, '{0, 0, 0, 0}},
      '{'{0, 0, 8, 8}, '{0, 0, 4, 4}, '{4, 4, 4, 4}},
      '{'{2, 2, 4, 4}, '{3, 3, 2, 2}, '{0, 0, 0, 0}},
      '{'{0, 4, 8, 4}, '{0, 4, 8, 2}, '{0, 0, 0, 0}},
      '{'{4, 0, 4, 8}, '{4, 0, 2, 8}, '{0, 0, 0, 0}}
   };

   localparam wgt3_t weight_tab [feature_num] = '{
      '{-3'sd1, 3'sd2, 3'sd0},
      '{-3'sd1, 3'sd2, 3'sd0},
      '{-3'sd1, 3'sd3, 3'sd0},
      '{-3'sd1, 3'sd3, 3'sd0},
      '{-3'sd1, 3'sd2, 3'sd2},
      '{-3'sd1, 3'sd3, 3'sd0},
      '{-3'sd1, 3'sd2, 3'sd0},
      '{-3'sd1, 3'sd2, 3'sd0}
   };

   localparam fthr_t fthr_tab [feature_num] = '{
      10'sd4, 10'sd3, -10'sd2, 10'sd5, 10'sd2, -10'sd3, 10'sd1, 10'sd6
   };

   localparam leaf_t leaf_left_tab [feature_num] = '{
      -10'sd40, -10'sd30, 10'sd25, -10'sd20, 10'sd35, -10'sd15, 10'sd20, -10'sd25
   };

   localparam leaf_t leaf_right_tab [feature_num] = '{
      10'sd60, 10'sd50, -10'sd35, 10'sd40, -10'sd10, 10'sd30, -10'sd20, 10'sd45
   };

   localparam ssum_t sthr_tab [stage_num] = '{14'sd0, 14'sd10, 14'sd5};

   // True when n features complete a stage that is not the last one
   function automatic logic stage_boundary(input int n);
      int   acc;
      logic hit;
      acc = 0;
      hit = 1'b0;
      for (int s = 0; s < stage_num - 1; s++) begin
         acc += stage_len[s];
         if (n == acc) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

endpackage

// ==== rects_mem.sv ====
`timescale 1ns/100ps

module rects_mem
   import haar_pkg::*;
(
   input  logic       clk,
   input  logic       local_rst,
   input  logic       clear,
   output logic       addr_valid,
   input  logic       addr_ready,
   output addr3_t     addr,
   output wgt3_t      wgt,
   output logic [1:0] mark
);

   logic [2:0] feat;
   logic [1:0] corner;   // TL, TR, BL, BR
   logic       armed;    // Low for one cycle after reset or clear
   logic       done;
   logic       fire;
   logic       eor;

   function automatic addr_t corner_addr(input logic [2:0] f, input logic [1:0] c,
                                         input int r);
      int x;
      int y;
      x = rect_tab[f][r][0] + (c[0] ? rect_tab[f][r][2] : 0);
      y = rect_tab[f][r][1] + (c[1] ? rect_tab[f][r][3] : 0);
      return addr_t'(y * (win_size + 1) + x);
   endfunction

   assign addr_valid = armed & ~done;
   assign fire       = addr_valid & addr_ready;

   assign addr.r0 = corner_addr(feat, corner, 0);
   assign addr.r1 = corner_addr(feat, corner, 1);
   assign addr.r2 = corner_addr(feat, corner, 2);
   assign wgt     = weight_tab[feat];

   // The three rectangles run side by side, so rectangle and feature end together
   assign eor  = (corner == 2'd3);
   assign mark = {eor, eor};

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         feat   <= '0;
         corner <= '0;
         armed  <= 1'b0;
         done   <= 1'b0;
      end else begin
         armed <= 1'b1;
         if (fire) begin
            corner <= corner + 2'd1;
            if (eor) begin
               if (feat == 3'(feature_num - 1)) begin
                  done <= 1'b1;   // Idle until the next window
               end else begin
                  feat <= feat + 3'd1;
               end
            end
         end
      end
   end

   a_addr_hold: assert property (
      @(posedge clk) disable iff (local_rst || clear)
      (addr_valid && !addr_ready) |=> $stable(addr)
   );

endmodule

// ==== rect_sum.sv ====
`timescale 1ns/100ps

module rect_sum
   import haar_pkg::*;
(
   input  logic    clk,
   input  logic    local_rst,
   input  logic    clear,
   input  logic    din_valid,
   output logic    din_ready,
   input  ii_t     din,
   input  weight_t weight,
   input  logic    last,
   output logic    dout_valid,
   input  logic    dout_ready,
   output rsum_t   dout
);

   logic [1:0] corner;
   rsum_t      acc;
   rsum_t      acc_next;
   logic       fire;

   // Only the closing corner has to wait for the output register
   assign din_ready = ~dout_valid | dout_ready | (corner != 2'd3);
   assign fire      = din_valid & din_ready;

   // Corner signs + - - +
   always_comb begin
      case (corner)
         2'd0:    acc_next = rsum_t'(din);
         2'd3:    acc_next = acc + rsum_t'(din);
         default: acc_next = acc - rsum_t'(din);
      endcase
   end

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         corner     <= '0;
         dout_valid <= 1'b0;
      end else begin
         if (fire) begin
            corner <= corner + 2'd1;
         end
         if (fire && last) begin
            dout_valid <= 1'b1;
         end else if (dout_ready) begin
            dout_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         acc <= acc_next;
      end
      if (fire && last) begin
         dout <= acc_next * weight;
      end
   end

   // The tag from the FIFO must line up with the local corner count
   a_last_corner: assert property (
      @(posedge clk) disable iff (local_rst || clear)
      fire |-> (last == (corner == 2'd3))
   );

endmodule

// ==== feature_val.sv ====
`timescale 1ns/100ps

module feature_val
   import haar_pkg::*;
(
   input  logic    clk,
   input  logic    local_rst,
   input  logic    clear,
   input  logic    din_valid,
   output logic    din_ready,
   input  fsum_t   din,
   input  logic    stddev_valid,
   output logic    stddev_ready,
   input  stddev_t stddev,
   output logic    dout_valid,
   input  logic    dout_ready,
   output leaf_t   dout
);

   logic               sd_held;
   stddev_t            sd_q;
   logic [2:0]         feat_idx;
   logic signed [26:0] thr_scaled;
   logic               fire;
   logic               sd_fire;

   assign stddev_ready = ~sd_held;
   assign sd_fire      = stddev_valid & stddev_ready;

   // No feature can be scored before the window's stddev is in
   assign din_ready = sd_held & (~dout_valid | dout_ready);
   assign fire      = din_valid & din_ready;

   assign thr_scaled = fthr_tab[feat_idx] * $signed({1'b0, sd_q});

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         sd_held    <= 1'b0;
         feat_idx   <= '0;
         dout_valid <= 1'b0;
      end else begin
         if (sd_fire) begin
            sd_held <= 1'b1;
         end
         if (fire) begin
            feat_idx   <= feat_idx + 3'd1;
            dout_valid <= 1'b1;
         end else if (dout_ready) begin
            dout_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sd_fire) begin
         sd_q <= stddev;
      end
      if (fire) begin
         dout <= (din < thr_scaled) ? leaf_left_tab[feat_idx] : leaf_right_tab[feat_idx];
      end
   end

endmodule

// ==== stage_sum.sv ====
`timescale 1ns/100ps

module stage_sum
   import haar_pkg::*;
(
   input  logic  clk,
   input  logic  local_rst,
   input  logic  clear,
   input  logic  din_valid,
   output logic  din_ready,
   input  leaf_t din,
   output logic  result_valid,
   input  logic  result_ready,
   output logic  result
);

   typedef enum logic {
      st_run,
      st_done
   } state_t;

   state_t     state;
   logic [1:0] stage_idx;
   logic [1:0] feat_cnt;
   ssum_t      acc;
   ssum_t      acc_next;
   logic       stage_end;
   logic       fire;

   assign din_ready    = (state == st_run);
   assign result_valid = (state == st_done);
   assign fire         = din_valid & din_ready;

   assign acc_next  = acc + ssum_t'(din);
   assign stage_end = (feat_cnt == 2'(stage_len[stage_idx] - 1));

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         state     <= st_run;
         stage_idx <= '0;
         feat_cnt  <= '0;
         acc       <= '0;
         result    <= 1'b0;
      end else begin
         case (state)
            st_run: begin
               if (fire && stage_end) begin
                  feat_cnt <= '0;
                  acc      <= '0;
                  if (acc_next < sthr_tab[stage_idx]) begin
                     result <= 1'b0;   // Early reject
                     state  <= st_done;
                  end else if (stage_idx == 2'(stage_num - 1)) begin
                     result <= 1'b1;
                     state  <= st_done;
                  end else begin
                     stage_idx <= stage_idx + 2'd1;
                  end
               end else if (fire) begin
                  feat_cnt <= feat_cnt + 2'd1;
                  acc      <= acc_next;
               end
            end
            st_done: begin
               if (result_ready) begin
                  state <= st_run;
               end
            end
            default: state <= st_run;
         endcase
      end
   end

   a_result_hold: assert property (
      @(posedge clk) disable iff (local_rst)
      (result_valid && !result_ready) |=> (result_valid && $stable(result))
   );

endmodule

// ==== classifier.sv ====
`timescale 1ns/100ps

module classifier
   import haar_pkg::*;
(
   input  logic    clk,
   input  logic    local_rst,
   output logic    addr_valid,
   input  logic    addr_ready,
   output addr3_t  addr,
   input  logic    din_valid,
   output logic    din_ready,
   input  din3_t   din,
   input  logic    stddev_valid,
   output logic    stddev_ready,
   input  stddev_t stddev,
   output logic    result_valid,
   input  logic    result_ready,
   output logic    result
);

   typedef struct packed {
      wgt3_t      wgt;
      logic [1:0] mark;   // {end of feature, end of rectangle}
   } tag_t;

   logic       clear;
   logic       rm_valid;
   logic       rm_ready;
   wgt3_t      rm_wgt;
   logic [1:0] rm_mark;
   tag_t       tag_mem [4];
   tag_t       tag_head;
   logic [1:0] wr_ptr;
   logic [1:0] rd_ptr;
   logic [2:0] tag_cnt;
   logic       tag_full;
   logic       addr_fire;
   logic       din_fire;
   logic [3:0] feat_issued;
   logic [3:0] feat_done;
   logic       feat_stall;
   ii_t        rs_din [3];
   weight_t    rs_wgt [3];
   logic [2:0] rs_din_ready;
   logic [2:0] rs_valid;
   rsum_t      rs_dout [3];
   logic       fsum_load;
   logic       fsum_valid;
   logic       fsum_ready;
   fsum_t      fsum;
   logic       leaf_valid;
   logic       leaf_ready;
   leaf_t      leaf;

   assign clear = result_valid & result_ready;   // Starts the next window

   rects_mem u_rects_mem (
      .clk        (clk),
      .local_rst  (local_rst),
      .clear      (clear),
      .addr_valid (rm_valid),
      .addr_ready (rm_ready),
      .addr       (addr),
      .wgt        (rm_wgt),
      .mark       (rm_mark)
   );

   // Hold off the next stage until the current one is decided
   assign feat_stall = stage_boundary(int'(feat_issued)) &
                       ((feat_done != feat_issued) | result_valid);

   assign tag_full   = (tag_cnt == 3'd4);
   assign rm_ready   = addr_ready & ~tag_full & ~feat_stall;
   assign addr_valid = rm_valid & ~tag_full & ~feat_stall;
   assign addr_fire  = addr_valid & addr_ready;
   assign din_ready  = &rs_din_ready;
   assign din_fire   = din_valid & din_ready;
   assign tag_head   = tag_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         tag_cnt     <= '0;
         feat_issued <= '0;
         feat_done   <= '0;
      end else begin
         if (addr_fire) begin
            wr_ptr <= wr_ptr + 2'd1;
         end
         if (din_fire) begin
            rd_ptr <= rd_ptr + 2'd1;
         end
         case ({addr_fire, din_fire})
            2'b10:   tag_cnt <= tag_cnt + 3'd1;
            2'b01:   tag_cnt <= tag_cnt - 3'd1;
            default: tag_cnt <= tag_cnt;
         endcase
         if (addr_fire && rm_mark[1]) begin
            feat_issued <= feat_issued + 4'd1;
         end
         if (leaf_valid && leaf_ready) begin
            feat_done <= feat_done + 4'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (addr_fire) begin
         tag_mem[wr_ptr] <= '{wgt: rm_wgt, mark: rm_mark};
      end
   end

   assign rs_din = '{din.d0, din.d1, din.d2};
   assign rs_wgt = '{tag_head.wgt.w0, tag_head.wgt.w1, tag_head.wgt.w2};

   for (genvar i = 0; i < 3; i++) begin : g_rect
      rect_sum u_rect_sum (
         .clk        (clk),
         .local_rst  (local_rst),
         .clear      (clear),
         .din_valid  (din_fire),   // All three take the triple together
         .din_ready  (rs_din_ready[i]),
         .din        (rs_din[i]),
         .weight     (rs_wgt[i]),
         .last       (tag_head.mark[0]),
         .dout_valid (rs_valid[i]),
         .dout_ready (fsum_load),
         .dout       (rs_dout[i])
      );
   end

   assign fsum_load = (&rs_valid) & (~fsum_valid | fsum_ready);

   always_ff @(posedge clk) begin
      if (local_rst || clear) begin
         fsum_valid <= 1'b0;
      end else if (fsum_load) begin
         fsum_valid <= 1'b1;
      end else if (fsum_ready) begin
         fsum_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fsum_load) begin
         fsum <= fsum_t'(rs_dout[0]) + fsum_t'(rs_dout[1]) + fsum_t'(rs_dout[2]);
      end
   end

   feature_val u_feature_val (
      .clk          (clk),
      .local_rst    (local_rst),
      .clear        (clear),
      .din_valid    (fsum_valid),
      .din_ready    (fsum_ready),
      .din          (fsum),
      .stddev_valid (stddev_valid),
      .stddev_ready (stddev_ready),
      .stddev       (stddev),
      .dout_valid   (leaf_valid),
      .dout_ready   (leaf_ready),
      .dout         (leaf)
   );

   stage_sum u_stage_sum (
      .clk          (clk),
      .local_rst    (local_rst),
      .clear        (clear),
      .din_valid    (leaf_valid),
      .din_ready    (leaf_ready),
      .din          (leaf),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result)
   );

   // Memory must never return more triples than were addressed
   a_din_has_tag: assert property (
      @(posedge clk) disable iff (local_rst || clear)
      din_fire |-> (tag_cnt != 3'd0)
   );

endmodule

// ==== classifier_tb.sv ====
`timescale 1ns/100ps

module classifier_tb
   import haar_pkg::*;
();

   localparam int max_windows = 40;
   localparam int cycle_limit = max_windows * 200;
   localparam int n_random    = 22;

   logic    clk;
   logic    local_rst;
   logic    addr_valid;
   logic    addr_ready;
   addr3_t  addr;
   logic    din_valid;
   logic    din_ready;
   din3_t   din;
   logic    stddev_valid;
   logic    stddev_ready;
   stddev_t stddev;
   logic    result_valid;
   logic    result_ready;
   logic    result;

   int     pix [win_size][win_size];
   int     ii_img [(win_size + 1) * (win_size + 1)];
   addr3_t exp_addr [$];
   addr3_t pend [$];   // Triples accepted but not yet answered
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     sva_errors = 0;
   int     cycles = 0;

   classifier UUT (
      .clk          (clk),
      .local_rst    (local_rst),
      .addr_valid   (addr_valid),
      .addr_ready   (addr_ready),
      .addr         (addr),
      .din_valid    (din_valid),
      .din_ready    (din_ready),
      .din          (din),
      .stddev_valid (stddev_valid),
      .stddev_ready (stddev_ready),
      .stddev       (stddev),
      .result_valid (result_valid),
      .result_ready (result_ready),
      .result       (result)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   a_sd_take: assert property (@(posedge clk) disable iff (local_rst)
      (stddev_valid && stddev_ready) |=> !stddev_ready)
      else begin
         $display("stddev_ready stayed high after a stddev transfer");
         sva_errors++;
      end

   a_sd_hold: assert property (@(posedge clk) disable iff (local_rst)
      (!stddev_ready && !(result_valid && result_ready)) |=> !stddev_ready)
      else begin
         $display("stddev_ready rose before the result was accepted");
         sva_errors++;
      end

   a_sd_rise: assert property (@(posedge clk) disable iff (local_rst)
      (result_valid && result_ready) |=> stddev_ready)
      else begin
         $display("stddev_ready stayed low after the result was accepted");
         sva_errors++;
      end

   // Bright bars in columns 2..3 outside rows 2..3, dim bars in columns 4..5
   function automatic int crafted_pixel(input int x, input int y);
      if ((x == 2 || x == 3) && !(y == 2 || y == 3)) return 10;
      if (x == 4 || x == 5) return 5;
      return 0;
   endfunction

   function automatic int rect_area_sum(input int x, input int y, input int w, input int h);
      return ii_img[(y + h) * 9 + x + w] - ii_img[y * 9 + x + w]
           - ii_img[(y + h) * 9 + x] + ii_img[y * 9 + x];
   endfunction

   function automatic int weight_of(input int f, input int r);
      case (r)
         0:       return int'(weight_tab[f].w0);
         1:       return int'(weight_tab[f].w1);
         default: return int'(weight_tab[f].w2);
      endcase
   endfunction

   // Corners in the order TL, TR, BL, BR
   function automatic int corner_index(input int f, input int r, input int c);
      int x;
      int y;
      x = rect_tab[f][r][0] + ((c % 2 == 1) ? rect_tab[f][r][2] : 0);
      y = rect_tab[f][r][1] + ((c >= 2) ? rect_tab[f][r][3] : 0);
      return y * (win_size + 1) + x;
   endfunction

   task automatic build_window(input int mode);
      int pmax;
      pmax = $urandom_range(1, 255);
      for (int y = 0; y < win_size; y++) begin
         for (int x = 0; x < win_size; x++) begin
            case (mode)
               0:       pix[y][x] = 0;
               1:       pix[y][x] = crafted_pixel(x, y);
               default: pix[y][x] = $urandom_range(0, pmax);
            endcase
         end
      end
      for (int y = 0; y <= win_size; y++) begin
         for (int x = 0; x <= win_size; x++) begin
            if (x == 0 || y == 0) ii_img[y * 9 + x] = 0;
            else ii_img[y * 9 + x] = pix[y - 1][x - 1] + ii_img[(y - 1) * 9 + x]
                                   + ii_img[y * 9 + x - 1] - ii_img[(y - 1) * 9 + x - 1];
         end
      end
   endtask

   // Expected outcome and the address triples of every evaluated feature
   task automatic model_window(input int sd, output int res);
      int     f;
      int     acc;
      int     fsum;
      addr3_t t;
      f   = 0;
      res = 1;
      exp_addr.delete();
      for (int s = 0; s < stage_num; s++) begin
         if (res == 1) begin
            acc = 0;
            for (int k = 0; k < stage_len[s]; k++) begin
               fsum = 0;
               for (int r = 0; r < 3; r++) begin
                  fsum += weight_of(f, r) * rect_area_sum(rect_tab[f][r][0],
                     rect_tab[f][r][1], rect_tab[f][r][2], rect_tab[f][r][3]);
               end
               for (int c = 0; c < 4; c++) begin
                  t.r0 = addr_t'(corner_index(f, 0, c));
                  t.r1 = addr_t'(corner_index(f, 1, c));
                  t.r2 = addr_t'(corner_index(f, 2, c));
                  exp_addr.push_back(t);
               end
               if (fsum < int'(fthr_tab[f]) * sd) acc += int'(leaf_left_tab[f]);
               else acc += int'(leaf_right_tab[f]);
               f++;
            end
            if (acc < int'(sthr_tab[s])) res = 0;   // Early reject
         end
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      tests_run++;
      if (errors + sva_errors == err_start) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: failed", name);
      end
   endtask

   task automatic run_window(input string name, input int mode);
      int sd;
      int exp_res;
      int n_exp;
      int n_addr;
      int gap;
      int err_start;
      bit din_go;
      bit sd_go;
      bit res_go;
      bit res_seen;
      bit done;
      err_start = errors + sva_errors;
      build_window(mode);
      sd = (mode == 2) ? $urandom_range(0, 64) : ((mode == 0) ? 10 : 1);
      model_window(sd, exp_res);
      n_exp = exp_addr.size();
      if (mode == 0) begin
         exp_res = 0;
         n_exp   = stage_len[0] * 4;
      end else if (mode == 1) begin
         exp_res = 1;
         n_exp   = feature_num * 4;
      end
      assert (stddev_ready && !result_valid && !addr_valid) else begin
         $display("%s: DUT not idle at the start of the window", name);
         errors++;
      end
      stddev       = stddev_t'(sd);
      stddev_valid = 1'b1;
      sd_go        = stddev_ready;
      din_go       = 1'b0;
      res_go       = 1'b0;
      res_seen     = 1'b0;
      done         = 1'b0;
      n_addr       = 0;
      gap          = $urandom_range(0, 3);
      while (!done) begin
         @(negedge clk);
         if (res_go) begin
            result_ready = 1'b0;
            done         = 1'b1;
         end else begin
            if (din_go) begin   // Triple taken at the last edge
               void'(pend.pop_front());
               din_valid = 1'b0;
               gap       = $urandom_range(0, 3);
            end
            if (!din_valid && pend.size() > 0) begin
               if (gap > 0) begin
                  gap--;
               end else begin
                  din.d0    = ii_t'(ii_img[pend[0].r0]);
                  din.d1    = ii_t'(ii_img[pend[0].r1]);
                  din.d2    = ii_t'(ii_img[pend[0].r2]);
                  din_valid = 1'b1;
               end
            end
            din_go = din_valid && din_ready;
            if (sd_go) stddev_valid = 1'b0;
            sd_go = stddev_valid && stddev_ready;
            result_ready = 1'b0;
            if (result_valid) begin
               if (!res_seen) begin
                  res_seen = 1'b1;
                  assert (int'(result) == exp_res) else begin
                     $display("** Error %s: result expected %0d, actual %0d",
                              name, exp_res, result);
                     errors++;
                  end
                  assert (n_addr == n_exp) else begin
                     $display("** Error %s: address triples expected %0d, actual %0d",
                              name, n_exp, n_addr);
                     errors++;
                  end
               end
               result_ready = ($urandom_range(0, 2) == 0);
            end
            res_go     = result_valid && result_ready;
            addr_ready = !res_go && ($urandom_range(0, 3) != 0);   // No overlap with clear
            if (addr_valid && addr_ready) begin
               if (n_addr < exp_addr.size()) begin
                  assert (addr == exp_addr[n_addr]) else begin
                     $display("** Error %s: address triple %0d expected %h, actual %h",
                              name, n_addr, exp_addr[n_addr], addr);
                     errors++;
                  end
               end else begin
                  $display("%s: address triple issued beyond the expected sequence", name);
                  errors++;
               end
               pend.push_back(addr);
               n_addr++;
            end
         end
      end
      assert (pend.size() == 0 && !din_valid) else begin
         $display("%s: memory still holds unanswered triples after the result", name);
         errors++;
      end
      report_test(name, err_start);
   endtask

   initial begin
      int err_start;
      void'($urandom(32'ha7cd0976));
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      local_rst    = 1'b1;
      addr_ready   = 1'b0;
      din_valid    = 1'b0;
      din          = '0;
      stddev_valid = 1'b0;
      stddev       = '0;
      result_ready = 1'b0;
      err_start    = 0;
      repeat (8) begin
         @(negedge clk);
         assert (!addr_valid && !result_valid && stddev_ready && din_ready) else begin
            $display("reset: a valid or ready output has the wrong level during reset");
            errors++;
         end
      end
      local_rst = 1'b0;
      report_test("reset", err_start);
      run_window("zero_window", 0);
      run_window("pass_window", 1);
      for (int i = 0; i < n_random; i++) begin
         run_window($sformatf("random_window_%0d", i), 2);
      end
      $display("Summary: %0d tests, %0d failed, %0d errors",
               tests_run, tests_failed, errors + sva_errors);
      if (errors + sva_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== files.f ====
haar_pkg.sv
rects_mem.sv
rect_sum.sv
feature_val.sv
stage_sum.sv
classifier.sv
classifier_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module classifier_tb -f files.f

out="$(./obj_dir/Vclassifier_tb)"
echo "$out"

echo "$out" | grep -q "^RESULT: PASS$"
